// File: compile.f
+incdir+testbench
verilog/drac_pkg.sv
verilog/datapath.sv
verilog/icache_interface.sv
verilog/dcache_interface.sv
verilog/top_drac.sv
testbench/tb_top_drac.sv

// File: run.sh
#!/bin/sh
# Build and run the DRAC core testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f compile.f \
    --top-module tb_top_drac -o sim_tb
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log
if grep -q "All checks passed" sim.log; then
    echo "Simulation PASSED"
    exit 0
fi
echo "Simulation FAILED"
exit 1

// File: testbench/tb_ref_model.svh
//--------------------------------------------------------------------------
// Reference ISA model and program builder
//--------------------------------------------------------------------------
`ifndef TB_REF_MODEL_SVH
`define TB_REF_MODEL_SVH

// Data memory contents before any store
function automatic logic [63:0] mem_fill(input logic [5:0] idx);
    return {{26'd0, idx} * 32'h9e37_79b9, 32'h5a00_0000 | {26'd0, idx}};
endfunction

// ADDI rd, rs1, imm
function automatic logic [31:0] addi_word(input logic [4:0] rd, input logic [4:0] rs1,
                                          input logic [11:0] imm);
    return {imm, rs1, 3'b000, rd, 7'b0010011};
endfunction

// LD rd, imm(x0)
function automatic logic [31:0] ld_word(input logic [4:0] rd, input logic [11:0] imm);
    return {imm, 5'd0, 3'b011, rd, 7'b0000011};
endfunction

// SD rs2, imm(x0), immediate split around the register fields
function automatic logic [31:0] sd_word(input logic [4:0] rs2, input logic [11:0] imm);
    return {imm[11:5], rs2, 5'd0, 3'b011, imm[4:0], 7'b0100011};
endfunction

// 64-word program, x0 as the base keeps every access 8-byte aligned
task automatic build_program();
    int k;
    int sel;
    logic [11:0] off;
    logic [11:0] imm;
    // Give x1..x31 known values first
    for (k = 1; k < 32; k++) begin
        prog[k - 1] = addi_word(5'(k), 5'd0, 12'($urandom_range(0, 2047)));
    end
    // Write to x0, negative immediate, store then load
    prog[31] = addi_word(5'd0, 5'd1, 12'hffb);
    prog[32] = addi_word(5'd7, 5'd7, 12'hf9c);
    prog[33] = sd_word(5'd5, 12'd16);
    prog[34] = ld_word(5'd9, 12'd16);
    for (k = 35; k < 63; k++) begin
        sel = int'($urandom_range(0, 15));
        // Eight slots only, so loads often hit earlier stores
        off = 12'(8 * $urandom_range(0, 7));
        imm = 12'(int'($urandom_range(0, 511)) - 256);
        if ((sel == 0) && (k > 48)) begin
            // LW is outside the subset
            prog[k] = {17'($urandom), 3'b010, 5'($urandom), 7'b0000011};
        end else if (sel < 7) begin
            prog[k] = addi_word(5'($urandom_range(0, 31)), 5'($urandom_range(0, 31)), imm);
        end else if (sel < 11) begin
            prog[k] = ld_word(5'($urandom_range(0, 31)), off);
        end else begin
            prog[k] = sd_word(5'($urandom_range(0, 31)), off);
        end
    end
    // SYSTEM opcode closes the loop back to the reset address
    prog[63] = {25'($urandom), 7'b1110011};
endtask

// Retires one instruction on the architectural state
function automatic void step_model(output logic [39:0] pc, output logic we,
                                   output logic [4:0] rd, output logic [63:0] data,
                                   output logic exc);
    logic [31:0] w;
    logic [6:0]  opc;
    logic [2:0]  f3;
    logic [63:0] base;
    logic [63:0] imm_i;
    logic [63:0] imm_s;
    logic [63:0] addr;
    w     = prog[ref_pc[7:2]];
    opc   = w[6:0];
    f3    = w[14:12];
    rd    = w[11:7];
    base  = ref_regs[w[19:15]];
    imm_i = {{52{w[31]}}, w[31:20]};
    imm_s = {{52{w[31]}}, w[31:25], w[11:7]};
    pc    = ref_pc;
    we    = 1'b0;
    data  = '0;
    exc   = 1'b0;
    if ((opc == 7'b0010011) && (f3 == 3'b000)) begin
        data = base + imm_i;
        we   = (rd != 5'd0);
    end else if ((opc == 7'b0000011) && (f3 == 3'b011)) begin
        addr = base + imm_i;
        data = ref_mem[addr[8:3]];
        we   = (rd != 5'd0);
    end else if ((opc == 7'b0100011) && (f3 == 3'b011)) begin
        addr = base + imm_s;
        ref_mem[addr[8:3]] = ref_regs[w[24:20]];
    end else begin
        exc = 1'b1;
    end
    if (we) begin
        ref_regs[rd] = data;
    end
    // Illegal words restart at the reset address
    ref_pc = exc ? RESET_ADDR : ref_pc + 40'd4;
endfunction

`endif

// File: testbench/tb_top_drac.sv
//--------------------------------------------------------------------------
// DRAC core testbench
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module tb_top_drac;

    localparam int          N_RETIRE       = 200;
    // Program plus the debug read sweep and some margin
    localparam int          TIMEOUT_CYCLES = N_RETIRE * 20 + 32 * 3 + 20;
    localparam logic [39:0] RESET_ADDR     = 40'h00_8000_0000;

    logic          clk_i                   = 1'b0;
    logic          reset_i                 = 1'b1;
    logic [39:0]   reset_addr_i            = RESET_ADDR;
    logic          icache_req_ready_i      = 1'b0;
    logic          icache_resp_valid_i     = 1'b0;
    logic [127:0]  icache_resp_datablock_i = '0;
    logic          dmem_req_ready_i        = 1'b0;
    logic          dmem_resp_valid_i       = 1'b0;
    logic          dmem_resp_nack_i        = 1'b0;
    logic [63:0]   dmem_resp_data_i        = '0;
    logic          reg_read_i              = 1'b0;
    logic [4:0]    reg_addr_i              = 5'd0;

    logic          icache_req_valid_o;
    logic [11:0]   icache_req_idx_o;
    logic          icache_resp_ready_o;
    logic          dmem_req_valid_o;
    logic [4:0]    dmem_req_cmd_o;
    logic [3:0]    dmem_op_type_o;
    logic [39:0]   dmem_req_addr_o;
    logic [63:0]   dmem_req_data_o;
    logic [7:0]    dmem_req_tag_o;
    logic [63:0]   reg_read_data_o;
    logic          wb_valid_o;
    logic [39:0]   wb_pc_o;
    logic          wb_we_o;
    logic [4:0]    wb_addr_o;
    logic [63:0]   wb_data_o;
    logic          csr_exception_o;
    logic [63:0]   csr_cause_o;
    logic [39:0]   csr_pc_o;

    // Program image and architectural model state
    logic [31:0]   prog     [0:63];
    logic [39:0]   ref_pc;
    logic [63:0]   ref_regs [0:31];
    logic [63:0]   ref_mem  [0:63];
    int            retired  = 0;
    int            cycles   = 0;

    // Expected retirement
    logic [39:0]   exp_pc;
    logic          exp_we;
    logic [4:0]    exp_rd;
    logic [63:0]   exp_data;
    logic          exp_exc;

    // Instruction cache model
    logic          ipend = 1'b0;
    int            iwait = 0;
    logic [11:0]   ireq_idx;
    logic [5:0]    iline;

    // Data cache model
    logic [63:0]   dmem [0:63];
    logic          dpend = 1'b0;
    int            dwait = 0;
    logic          dstore;
    logic [5:0]    didx;
    logic [63:0]   ddata;
    logic [7:0]    exp_tag;

    int            r;

    `include "tb_ref_model.svh"

    top_drac dut0 (
        .clk_i                   (clk_i),
        .reset_i                 (reset_i),
        .reset_addr_i            (reset_addr_i),
        .icache_req_ready_i      (icache_req_ready_i),
        .icache_resp_valid_i     (icache_resp_valid_i),
        .icache_resp_datablock_i (icache_resp_datablock_i),
        .icache_req_valid_o      (icache_req_valid_o),
        .icache_req_idx_o        (icache_req_idx_o),
        .icache_resp_ready_o     (icache_resp_ready_o),
        .dmem_req_ready_i        (dmem_req_ready_i),
        .dmem_resp_valid_i       (dmem_resp_valid_i),
        .dmem_resp_nack_i        (dmem_resp_nack_i),
        .dmem_resp_data_i        (dmem_resp_data_i),
        .dmem_req_valid_o        (dmem_req_valid_o),
        .dmem_req_cmd_o          (dmem_req_cmd_o),
        .dmem_op_type_o          (dmem_op_type_o),
        .dmem_req_addr_o         (dmem_req_addr_o),
        .dmem_req_data_o         (dmem_req_data_o),
        .dmem_req_tag_o          (dmem_req_tag_o),
        .reg_read_i              (reg_read_i),
        .reg_addr_i              (reg_addr_i),
        .reg_read_data_o         (reg_read_data_o),
        .wb_valid_o              (wb_valid_o),
        .wb_pc_o                 (wb_pc_o),
        .wb_we_o                 (wb_we_o),
        .wb_addr_o               (wb_addr_o),
        .wb_data_o               (wb_data_o),
        .csr_exception_o         (csr_exception_o),
        .csr_cause_o             (csr_cause_o),
        .csr_pc_o                (csr_pc_o)
    );

    // 8 ns period
    always #4 clk_i = ~clk_i;

    task automatic fail_run();
        $display("Checks failed");
        $fatal(1);
    endtask

    task automatic flag_mismatch(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
        $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
        fail_run();
    endtask

    task automatic stop_with_error(input string what);
        $display("Error at %0t: %s", $time, what);
        fail_run();
    endtask

    // Watchdog
    always @(posedge clk_i) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            stop_with_error("timeout, the core stopped retiring instructions");
        end
    end

    // Instruction cache model with random ready and 0 to 3 cycles of response delay
    always @(posedge clk_i) begin
        if (reset_i) begin
            icache_req_ready_i  <= 1'b0;
            icache_resp_valid_i <= 1'b0;
            ipend = 1'b0;
        end else begin
            icache_resp_valid_i <= 1'b0;
            // No new fetch once the program length is reached
            icache_req_ready_i  <= ($urandom_range(0, 3) != 0) && (retired < N_RETIRE);
            if (icache_resp_valid_i) begin
                assert (icache_resp_ready_o)
                else stop_with_error("icache response arrived while resp_ready was low");
            end
            if (ipend) begin
                if (iwait == 0) begin
                    iline = {ireq_idx[7:4], 2'b00};
                    icache_resp_datablock_i <= {prog[iline + 6'd3], prog[iline + 6'd2],
                                                prog[iline + 6'd1], prog[iline]};
                    icache_resp_valid_i     <= 1'b1;
                    ipend = 1'b0;
                end else begin
                    iwait = iwait - 1;
                end
            end else if (icache_req_valid_o && icache_req_ready_i) begin
                // Fetch index follows the model pc
                assert (icache_req_idx_o == ref_pc[11:0])
                else flag_mismatch("icache_req_idx_o", 64'(icache_req_idx_o),
                                   64'(ref_pc[11:0]));
                ireq_idx = icache_req_idx_o;
                ipend    = 1'b1;
                iwait    = int'($urandom_range(0, 3));
            end
        end
    end

    // Data cache model with random ready and a nack on about one response in four
    always @(posedge clk_i) begin
        if (reset_i) begin
            dmem_req_ready_i  <= 1'b0;
            dmem_resp_valid_i <= 1'b0;
            dmem_resp_nack_i  <= 1'b0;
            dpend   = 1'b0;
            exp_tag = 8'd0;
            for (int i = 0; i < 64; i++) begin
                dmem[i] = mem_fill(6'(i));
            end
        end else begin
            dmem_resp_valid_i <= 1'b0;
            dmem_resp_nack_i  <= 1'b0;
            dmem_req_ready_i  <= ($urandom_range(0, 3) != 0);
            if (dpend) begin
                if (dwait == 0) begin
                    dmem_resp_valid_i <= 1'b1;
                    // Nacked access leaves memory untouched
                    if ($urandom_range(0, 3) == 0) begin
                        dmem_resp_nack_i <= 1'b1;
                    end else if (dstore) begin
                        dmem[didx] = ddata;
                        dmem_resp_data_i <= ~ddata;
                    end else begin
                        dmem_resp_data_i <= dmem[didx];
                    end
                    dpend = 1'b0;
                end else begin
                    dwait = dwait - 1;
                end
            end else if (dmem_req_valid_o && dmem_req_ready_i) begin
                // One tag step per accepted request including replays
                assert (dmem_req_tag_o == exp_tag)
                else flag_mismatch("dmem_req_tag_o", 64'(dmem_req_tag_o), 64'(exp_tag));
                assert (dmem_op_type_o == 4'b0011)
                else flag_mismatch("dmem_op_type_o", 64'(dmem_op_type_o), 64'd3);
                assert (dmem_req_addr_o[2:0] == 3'd0)
                else stop_with_error("data request address is not 8-byte aligned");
                // Read or write follows the opcode of the instruction in flight
                dstore  = (prog[ref_pc[7:2]][6:0] == 7'b0100011);
                assert (dmem_req_cmd_o == (dstore ? 5'b00001 : 5'b00000))
                else flag_mismatch("dmem_req_cmd_o", 64'(dmem_req_cmd_o), 64'(dstore));
                didx    = dmem_req_addr_o[8:3];
                ddata   = dmem_req_data_o;
                exp_tag = exp_tag + 8'd1;
                dpend   = 1'b1;
                dwait   = int'($urandom_range(0, 3));
            end
        end
    end

    // Compare each retirement with the model
    always @(posedge clk_i) begin
        if (reset_i) begin
            ref_pc = RESET_ADDR;
            for (int i = 0; i < 32; i++) begin
                ref_regs[i] = '0;
            end
            for (int i = 0; i < 64; i++) begin
                ref_mem[i] = mem_fill(6'(i));
            end
        end else if (wb_valid_o) begin
            step_model(exp_pc, exp_we, exp_rd, exp_data, exp_exc);
            assert (wb_pc_o == exp_pc)
            else flag_mismatch("wb_pc_o", 64'(wb_pc_o), 64'(exp_pc));
            assert (wb_we_o == exp_we)
            else flag_mismatch("wb_we_o", 64'(wb_we_o), 64'(exp_we));
            if (exp_we) begin
                assert (wb_addr_o == exp_rd)
                else flag_mismatch("wb_addr_o", 64'(wb_addr_o), 64'(exp_rd));
                assert (wb_data_o == exp_data)
                else flag_mismatch("wb_data_o", wb_data_o, exp_data);
            end
            assert (csr_exception_o == exp_exc)
            else flag_mismatch("csr_exception_o", 64'(csr_exception_o), 64'(exp_exc));
            if (exp_exc) begin
                assert (csr_cause_o == 64'd2)
                else flag_mismatch("csr_cause_o", csr_cause_o, 64'd2);
                assert (csr_pc_o == exp_pc)
                else flag_mismatch("csr_pc_o", 64'(csr_pc_o), 64'(exp_pc));
            end
            retired = retired + 1;
        end
    end

    initial begin
        void'($urandom(32'h7840_8d59));
        build_program();
        repeat (2) @(posedge clk_i);
        reset_i <= 1'b0;
        // Still the reset values here
        @(posedge clk_i);
        assert (!icache_req_valid_o && !dmem_req_valid_o && !wb_valid_o && !csr_exception_o)
        else stop_with_error("request or retire outputs active right after reset");
        wait (retired == N_RETIRE);
        // Core now idles waiting for a fetch that never comes
        for (r = 0; r < 32; r++) begin
            @(posedge clk_i);
            reg_read_i <= 1'b1;
            reg_addr_i <= 5'(r);
            @(posedge clk_i);
            reg_read_i <= 1'b0;
            @(posedge clk_i);
            assert (reg_read_data_o == ref_regs[r])
            else flag_mismatch($sformatf("reg_read_data_o x%0d", r), reg_read_data_o,
                               ref_regs[r]);
        end
        $display("All checks passed");
        $finish;
    end

endmodule

// File: verilog/top_drac.sv
//--------------------------------------------------------------------------
// DRAC core top
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module top_drac (
    input  logic                   clk_i,
    input  logic                   reset_i,
    input  drac_pkg::addr_t        reset_addr_i,

    // Instruction cache
    input  logic                   icache_req_ready_i,
    input  logic                   icache_resp_valid_i,
    input  drac_pkg::icache_line_t icache_resp_datablock_i,
    output logic                   icache_req_valid_o,
    output logic [11:0]            icache_req_idx_o,
    output logic                   icache_resp_ready_o,

    // Data cache
    input  logic                   dmem_req_ready_i,
    input  logic                   dmem_resp_valid_i,
    input  logic                   dmem_resp_nack_i,
    input  drac_pkg::bus64_t       dmem_resp_data_i,
    output logic                   dmem_req_valid_o,
    output logic [4:0]             dmem_req_cmd_o,
    output logic [3:0]             dmem_op_type_o,
    output drac_pkg::addr_t        dmem_req_addr_o,
    output drac_pkg::bus64_t       dmem_req_data_o,
    output logic [7:0]             dmem_req_tag_o,

    // Debug register read
    input  logic                   reg_read_i,
    input  logic [4:0]             reg_addr_i,
    output drac_pkg::bus64_t       reg_read_data_o,

    // Write-back trace
    output logic                   wb_valid_o,
    output drac_pkg::addr_t        wb_pc_o,
    output logic                   wb_we_o,
    output logic [4:0]             wb_addr_o,
    output drac_pkg::bus64_t       wb_data_o,

    // Exception report
    output logic                   csr_exception_o,
    output drac_pkg::bus64_t       csr_cause_o,
    output drac_pkg::addr_t        csr_pc_o
);
    import drac_pkg::*;

    // Datapath to instruction side
    logic        fetch_req;
    addr_t       fetch_pc;
    logic        fetch_valid;
    logic [31:0] fetch_instr;

    // Datapath to data side
    logic        mem_req;
    logic        mem_store;
    addr_t       mem_addr;
    bus64_t      mem_wdata;
    logic        mem_done;
    bus64_t      mem_rdata;

    datapath datapath_inst (
        .clk_i           (clk_i),
        .reset_i         (reset_i),
        .reset_addr_i    (reset_addr_i),
        .fetch_valid_i   (fetch_valid),
        .fetch_instr_i   (fetch_instr),
        .fetch_req_o     (fetch_req),
        .fetch_pc_o      (fetch_pc),
        .mem_done_i      (mem_done),
        .mem_rdata_i     (mem_rdata),
        .mem_req_o       (mem_req),
        .mem_store_o     (mem_store),
        .mem_addr_o      (mem_addr),
        .mem_wdata_o     (mem_wdata),
        .reg_read_i      (reg_read_i),
        .reg_addr_i      (reg_addr_i),
        .reg_read_data_o (reg_read_data_o),
        .wb_valid_o      (wb_valid_o),
        .wb_pc_o         (wb_pc_o),
        .wb_we_o         (wb_we_o),
        .wb_addr_o       (wb_addr_o),
        .wb_data_o       (wb_data_o),
        .csr_exception_o (csr_exception_o),
        .csr_cause_o     (csr_cause_o),
        .csr_pc_o        (csr_pc_o)
    );

    icache_interface icache_interface_inst (
        .clk_i                   (clk_i),
        .reset_i                 (reset_i),
        .fetch_req_i             (fetch_req),
        .fetch_pc_i              (fetch_pc),
        .fetch_valid_o           (fetch_valid),
        .fetch_instr_o           (fetch_instr),
        .icache_req_ready_i      (icache_req_ready_i),
        .icache_resp_valid_i     (icache_resp_valid_i),
        .icache_resp_datablock_i (icache_resp_datablock_i),
        .icache_req_valid_o      (icache_req_valid_o),
        .icache_req_idx_o        (icache_req_idx_o),
        .icache_resp_ready_o     (icache_resp_ready_o)
    );

    dcache_interface dcache_interface_inst (
        .clk_i             (clk_i),
        .reset_i           (reset_i),
        .mem_req_i         (mem_req),
        .mem_store_i       (mem_store),
        .mem_addr_i        (mem_addr),
        .mem_wdata_i       (mem_wdata),
        .mem_done_o        (mem_done),
        .mem_rdata_o       (mem_rdata),
        .dmem_req_ready_i  (dmem_req_ready_i),
        .dmem_resp_valid_i (dmem_resp_valid_i),
        .dmem_resp_nack_i  (dmem_resp_nack_i),
        .dmem_resp_data_i  (dmem_resp_data_i),
        .dmem_req_valid_o  (dmem_req_valid_o),
        .dmem_req_cmd_o    (dmem_req_cmd_o),
        .dmem_op_type_o    (dmem_op_type_o),
        .dmem_req_addr_o   (dmem_req_addr_o),
        .dmem_req_data_o   (dmem_req_data_o),
        .dmem_req_tag_o    (dmem_req_tag_o)
    );

endmodule

// File: verilog/dcache_interface.sv
//--------------------------------------------------------------------------
// Data cache interface
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module dcache_interface (
    input  logic               clk_i,
    input  logic               reset_i,

    // Request from the datapath
    input  logic               mem_req_i,
    input  logic               mem_store_i,
    input  drac_pkg::addr_t    mem_addr_i,
    input  drac_pkg::bus64_t   mem_wdata_i,
    output logic               mem_done_o,
    output drac_pkg::bus64_t   mem_rdata_o,

    // Data cache response
    input  logic               dmem_req_ready_i,
    input  logic               dmem_resp_valid_i,
    input  logic               dmem_resp_nack_i,
    input  drac_pkg::bus64_t   dmem_resp_data_i,

    // Data cache request
    output logic               dmem_req_valid_o,
    output logic [4:0]         dmem_req_cmd_o,
    output logic [3:0]         dmem_op_type_o,
    output drac_pkg::addr_t    dmem_req_addr_o,
    output drac_pkg::bus64_t   dmem_req_data_o,
    output logic [7:0]         dmem_req_tag_o
);
    import drac_pkg::*;

    localparam logic [1:0] S_IDLE = 2'd0;
    localparam logic [1:0] S_REQ  = 2'd1;
    localparam logic [1:0] S_WAIT = 2'd2;

    logic [1:0] state_q;
    logic [7:0] tag_q;
    logic       store_q;
    addr_t      addr_q;
    bus64_t     wdata_q;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q <= S_IDLE;
            tag_q   <= 8'd0;
        end else begin
            case (state_q)
                S_IDLE: begin
                    if (mem_req_i) begin
                        state_q <= S_REQ;
                    end
                end
                // Tag advances on every accepted request
                S_REQ: begin
                    if (dmem_req_ready_i) begin
                        tag_q   <= tag_q + 8'd1;
                        state_q <= S_WAIT;
                    end
                end
                // Nack sends the same request again next cycle
                S_WAIT: begin
                    if (dmem_resp_valid_i) begin
                        state_q <= dmem_resp_nack_i ? S_REQ : S_IDLE;
                    end
                end
                default: begin
                    state_q <= S_IDLE;
                end
            endcase
        end
    end

    // Request fields, stable through stalls and replays
    always_ff @(posedge clk_i) begin
        if ((state_q == S_IDLE) && mem_req_i) begin
            store_q <= mem_store_i;
            addr_q  <= mem_addr_i;
            wdata_q <= mem_wdata_i;
        end
    end

    assign dmem_req_valid_o = (state_q == S_REQ);
    assign dmem_req_cmd_o   = store_q ? M_XWR : M_XRD;
    assign dmem_op_type_o   = MT_D;
    assign dmem_req_addr_o  = addr_q;
    assign dmem_req_data_o  = wdata_q;
    assign dmem_req_tag_o   = tag_q;

    // Clean response completes the access
    assign mem_done_o  = (state_q == S_WAIT) && dmem_resp_valid_i && !dmem_resp_nack_i;
    assign mem_rdata_o = dmem_resp_data_i;

endmodule

// File: verilog/icache_interface.sv
//--------------------------------------------------------------------------
// Instruction cache interface
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module icache_interface (
    input  logic                   clk_i,
    input  logic                   reset_i,

    // Fetch request from the datapath
    input  logic                   fetch_req_i,
    input  drac_pkg::addr_t        fetch_pc_i,
    output logic                   fetch_valid_o,
    output logic [31:0]            fetch_instr_o,

    // Instruction cache
    input  logic                   icache_req_ready_i,
    input  logic                   icache_resp_valid_i,
    input  drac_pkg::icache_line_t icache_resp_datablock_i,
    output logic                   icache_req_valid_o,
    output logic [11:0]            icache_req_idx_o,
    output logic                   icache_resp_ready_o
);

    localparam logic [1:0] S_IDLE = 2'd0;
    localparam logic [1:0] S_REQ  = 2'd1;
    localparam logic [1:0] S_WAIT = 2'd2;

    logic [1:0]  state_q;
    // Page offset of the fetch pc
    logic [11:0] idx_q;

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q <= S_IDLE;
        end else begin
            case (state_q)
                S_IDLE: begin
                    if (fetch_req_i) begin
                        state_q <= S_REQ;
                    end
                end
                // Hold the request until the cache takes it
                S_REQ: begin
                    if (icache_req_ready_i) begin
                        state_q <= S_WAIT;
                    end
                end
                S_WAIT: begin
                    if (icache_resp_valid_i) begin
                        state_q <= S_IDLE;
                    end
                end
                default: begin
                    state_q <= S_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if ((state_q == S_IDLE) && fetch_req_i) begin
            idx_q <= fetch_pc_i[11:0];
        end
    end

    assign icache_req_valid_o  = (state_q == S_REQ);
    assign icache_req_idx_o    = idx_q;
    assign icache_resp_ready_o = (state_q == S_WAIT);

    // One 32-bit word out of the 128-bit line, by pc[3:2]
    assign fetch_valid_o = (state_q == S_WAIT) && icache_resp_valid_i;
    assign fetch_instr_o = icache_resp_datablock_i[{idx_q[3:2], 5'b00000} +: 32];

endmodule

// File: verilog/datapath.sv
//--------------------------------------------------------------------------
// Multi-cycle datapath
//--------------------------------------------------------------------------
`timescale 1ns/1ps

module datapath (
    input  logic               clk_i,
    input  logic               reset_i,
    input  drac_pkg::addr_t    reset_addr_i,

    // Fetch side
    input  logic               fetch_valid_i,
    input  logic [31:0]        fetch_instr_i,
    output logic               fetch_req_o,
    output drac_pkg::addr_t    fetch_pc_o,

    // Data memory side
    input  logic               mem_done_i,
    input  drac_pkg::bus64_t   mem_rdata_i,
    output logic               mem_req_o,
    output logic               mem_store_o,
    output drac_pkg::addr_t    mem_addr_o,
    output drac_pkg::bus64_t   mem_wdata_o,

    // Debug register read
    input  logic               reg_read_i,
    input  logic [4:0]         reg_addr_i,
    output drac_pkg::bus64_t   reg_read_data_o,

    // Write-back trace
    output logic               wb_valid_o,
    output drac_pkg::addr_t    wb_pc_o,
    output logic               wb_we_o,
    output logic [4:0]         wb_addr_o,
    output drac_pkg::bus64_t   wb_data_o,

    // Exception report
    output logic               csr_exception_o,
    output drac_pkg::bus64_t   csr_cause_o,
    output drac_pkg::addr_t    csr_pc_o
);
    import drac_pkg::*;

    // Sequencer states
    localparam logic [2:0] S_FETCH      = 3'd0;
    localparam logic [2:0] S_WAIT_FETCH = 3'd1;
    localparam logic [2:0] S_EXEC       = 3'd2;
    localparam logic [2:0] S_WAIT_MEM   = 3'd3;
    localparam logic [2:0] S_WB         = 3'd4;

    logic [2:0] state_q;
    logic       fetch_req_q;
    addr_t      pc_q;
    instr_u     instr_q;
    bus64_t     result_q;
    bus64_t     reg_read_data_q;

    // x1..x31, x0 is not stored
    bus64_t     rf_q [31:1];

    logic       is_addi;
    logic       is_load;
    logic       is_store;
    logic       illegal;
    logic       writes_rd;
    logic [4:0] rs1;
    logic [4:0] rs2;
    logic [4:0] rd;
    bus64_t     rs1_val;
    bus64_t     rs2_val;
    bus64_t     imm_i;
    bus64_t     imm_s;
    bus64_t     eff_addr;

    // Register read with x0 hardwired to zero
    function automatic bus64_t rf_read(input logic [4:0] idx);
        bus64_t val;
        val = '0;
        if (idx != 5'd0) begin
            val = rf_q[idx];
        end
        return val;
    endfunction

    // Decode, same word through both views
    assign is_addi  = (instr_q.i.opcode == OP_IMM)   && (instr_q.i.funct3 == F3_ADDI);
    assign is_load  = (instr_q.i.opcode == OP_LOAD)  && (instr_q.i.funct3 == F3_DOUBLE);
    assign is_store = (instr_q.s.opcode == OP_STORE) && (instr_q.s.funct3 == F3_DOUBLE);
    assign illegal   = !(is_addi || is_load || is_store);
    assign writes_rd = is_addi || is_load;

    assign rs1 = instr_q.i.rs1;
    assign rs2 = instr_q.s.rs2;
    assign rd  = instr_q.i.rd;

    // Sign-extended immediates
    assign imm_i = {{52{instr_q.i.imm[11]}}, instr_q.i.imm};
    assign imm_s = {{52{instr_q.s.imm_hi[6]}}, instr_q.s.imm_hi, instr_q.s.imm_lo};

    assign rs1_val  = rf_read(rs1);
    assign rs2_val  = rf_read(rs2);
    // rs1 plus the I or S immediate
    assign eff_addr = rs1_val + (is_store ? imm_s : imm_i);

    // Control sequencer
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q     <= S_FETCH;
            fetch_req_q <= 1'b0;
            pc_q        <= reset_addr_i;
        end else begin
            fetch_req_q <= 1'b0;
            case (state_q)
                // Only entered out of reset
                S_FETCH: begin
                    fetch_req_q <= 1'b1;
                    state_q     <= S_WAIT_FETCH;
                end
                S_WAIT_FETCH: begin
                    if (fetch_valid_i) begin
                        state_q <= S_EXEC;
                    end
                end
                // Illegal words skip memory and retire directly
                S_EXEC: begin
                    state_q <= (is_load || is_store) ? S_WAIT_MEM : S_WB;
                end
                S_WAIT_MEM: begin
                    if (mem_done_i) begin
                        state_q <= S_WB;
                    end
                end
                // Retire, then request the next fetch straight away
                S_WB: begin
                    fetch_req_q <= 1'b1;
                    state_q     <= S_WAIT_FETCH;
                    pc_q        <= illegal ? reset_addr_i : pc_q + 40'd4;
                end
                default: begin
                    state_q <= S_FETCH;
                end
            endcase
        end
    end

    // Instruction, result and register file
    always_ff @(posedge clk_i) begin
        if ((state_q == S_WAIT_FETCH) && fetch_valid_i) begin
            instr_q <= fetch_instr_i;
        end
        // ADDI result, overwritten by load data below
        if (state_q == S_EXEC) begin
            result_q <= rs1_val + imm_i;
        end
        if ((state_q == S_WAIT_MEM) && mem_done_i) begin
            result_q <= mem_rdata_i;
        end
        if (wb_we_o) begin
            rf_q[rd] <= result_q;
        end
    end

    // Debug port, data one cycle after the strobe
    always_ff @(posedge clk_i) begin
        if (reg_read_i) begin
            reg_read_data_q <= rf_read(reg_addr_i);
        end
    end

    assign fetch_req_o = fetch_req_q;
    assign fetch_pc_o  = pc_q;

    // Memory request pulses in the execute cycle
    assign mem_req_o   = (state_q == S_EXEC) && (is_load || is_store);
    assign mem_store_o = is_store;
    assign mem_addr_o  = eff_addr[39:0];
    assign mem_wdata_o = rs2_val;

    // Trace, writes to x0 are dropped
    assign wb_valid_o = (state_q == S_WB);
    assign wb_pc_o    = pc_q;
    assign wb_we_o    = wb_valid_o && writes_rd && (rd != 5'd0);
    assign wb_addr_o  = rd;
    assign wb_data_o  = result_q;

    assign csr_exception_o = wb_valid_o && illegal;
    assign csr_cause_o     = csr_exception_o ? CAUSE_ILLEGAL_INSTR : '0;
    assign csr_pc_o        = pc_q;

    assign reg_read_data_o = reg_read_data_q;

endmodule

// File: verilog/drac_pkg.sv
//--------------------------------------------------------------------------
// DRAC core shared definitions
//--------------------------------------------------------------------------
package drac_pkg;

    // Core widths
    typedef logic [39:0]  addr_t;
    typedef logic [63:0]  bus64_t;
    typedef logic [127:0] icache_line_t;

    // I-type layout, ADDI and LD
    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } instr_itype_t;

    // S-type layout, SD only
    // Immediate split around rs2 and rs1
    typedef struct packed {
        logic [6:0]  imm_hi;
        logic [4:0]  rs2;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  imm_lo;
        logic [6:0]  opcode;
    } instr_stype_t;

    // One fetched word, seen either way
    typedef union packed {
        instr_itype_t i;
        instr_stype_t s;
    } instr_u;

    // Major opcodes
    localparam logic [6:0] OP_IMM   = 7'b0010011;
    localparam logic [6:0] OP_LOAD  = 7'b0000011;
    localparam logic [6:0] OP_STORE = 7'b0100011;

    // funct3 values
    localparam logic [2:0] F3_ADDI   = 3'b000;
    localparam logic [2:0] F3_DOUBLE = 3'b011;

    // Data cache command codes
    localparam logic [4:0] M_XRD = 5'b00000;
    localparam logic [4:0] M_XWR = 5'b00001;

    // Doubleword access type
    localparam logic [3:0] MT_D = 4'b0011;

    // mcause value for an illegal instruction
    localparam logic [63:0] CAUSE_ILLEGAL_INSTR = 64'd2;

endpackage
